// ==== files.f ====
+incdir+testbench
src/crtc_pkg.sv
src/crtc_regs.sv
src/sync_gen.sv
src/addr_gen.sv
src/dot_gen.sv
src/video_top.sv
testbench/tb_video.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary -Wno-fatal
TOP      = tb_video
FILELIST = files.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/crtc_model.svh ====
`ifndef CRTC_MODEL_SVH
`define CRTC_MODEL_SVH

logic [7:0]  m_regs [REG_COUNT];
logic [4:0]  m_pix;                 // Pixel within character
logic [7:0]  m_hchar;
logic [4:0]  m_ra;                  // Scanline within row
logic [7:0]  m_vchar;
logic [13:0] m_ma;
logic [13:0] m_row;
logic [7:0]  m_data = 8'h00;        // Bus data for the previous address
logic [7:0]  m_code;
logic [7:0]  m_glyph;
logic [7:0]  m_shift;
logic        m_rev;
logic        m_en;

function automatic int sync_width(input logic [3:0] code);
    return (code == 4'd0) ? 16 : int'(code);   // Zero selects 16 characters
endfunction

function automatic logic in_window(input logic [7:0] pos, input logic [7:0] start,
                                   input logic [3:0] code);
    return (pos >= start) && (int'(pos) < int'(start) + sync_width(code));
endfunction

function automatic logic [11:0] predict_addr();
    if (m_pix < 5'd2) begin
        return {1'b0, m_ma[10:0]};                 // Character code from video RAM
    end
    return FONT_BASE + {2'b00, m_code[6:0], 3'b000} + {9'd0, m_ra[2:0]};
endfunction

function automatic logic predict_video();
    return (m_shift[7] ^ m_rev) & m_en;
endfunction

task automatic reset_model();
    for (int i = 0; i < REG_COUNT; i++) begin
        m_regs[i] = REG_DEFAULT[i];
    end
    m_pix   = '0;
    m_hchar = '0;
    m_ra    = '0;
    m_vchar = '0;
    m_ma    = {m_regs[R12_DISPLAY_START_HI][5:0], m_regs[R13_DISPLAY_START_LO]};
    m_row   = m_ma;
    m_code  = '0;
    m_glyph = '0;
    m_shift = '0;
    m_rev   = 1'b0;
    m_en    = 1'b0;
endtask

task automatic step_model(input logic wr, input logic [3:0] sel, input logic [7:0] wdata);
    logic char_end;
    logic line_end;
    logic last_line;
    logic frame_end;
    logic visible;
    char_end  = m_pix == 5'd7;
    line_end  = char_end && (m_hchar == m_regs[R0_H_TOTAL]);
    last_line = m_ra == m_regs[R9_SCAN_LINE][4:0];
    frame_end = line_end && last_line && (m_vchar == {1'b0, m_regs[R4_V_TOTAL][6:0]});
    visible   = (m_hchar < m_regs[R1_H_DISPLAYED]) &&
                (m_vchar < {1'b0, m_regs[R6_V_DISPLAYED][6:0]});

    // Code after pixel 1, glyph after pixel 3, shifter load after pixel 7
    if (m_pix == 5'd1) begin
        m_code = m_data;
    end
    if (m_pix == 5'd3) begin
        m_glyph = m_data;
    end
    if (char_end) begin
        m_shift = m_glyph;
        m_rev   = m_code[7];
        m_en    = visible;
    end else begin
        m_shift = m_shift << 1;
    end

    if (frame_end) begin
        m_ma  = {m_regs[R12_DISPLAY_START_HI][5:0], m_regs[R13_DISPLAY_START_LO]};
        m_row = m_ma;
    end else if (line_end && last_line) begin
        m_row = m_row + {6'd0, m_regs[R1_H_DISPLAYED]};
        m_ma  = m_row;
    end else if (line_end) begin
        m_ma = m_row;                               // Same row again
    end else if (char_end) begin
        m_ma = m_ma + 14'd1;
    end

    if (line_end) begin
        m_ra = last_line ? 5'd0 : m_ra + 5'd1;
        if (last_line) begin
            m_vchar = frame_end ? 8'd0 : m_vchar + 8'd1;
        end
    end
    m_hchar = line_end ? 8'd0 : (char_end ? m_hchar + 8'd1 : m_hchar);
    m_pix   = char_end ? 5'd0 : m_pix + 5'd1;

    if (wr && (sel < REG_COUNT)) begin
        m_regs[sel] = wdata;                        // Seen by the model from the next cycle
    end
endtask

`endif

// ==== testbench/tb_video.sv ====
`timescale 1ns/1ps

module tb_video
    import crtc_pkg::*;
();
    localparam logic [BUS_W-1:0] FONT_BASE = 12'h800;

    logic             pixel_clk_i = 1'b0;
    logic             reset_i     = 1'b1;
    logic             reg_wr_i    = 1'b0;
    logic [3:0]       reg_sel_i   = 4'd0;
    logic [7:0]       reg_data_i  = 8'h00;
    logic [7:0]       bus_data_i  = 8'h00;
    logic [BUS_W-1:0] bus_addr_o;
    logic             h_sync_o;
    logic             v_sync_o;
    logic             video_o;

    logic [7:0]       vram [2048];              // Character codes
    logic [7:0]       font [2048];              // Glyph rows
    logic [31:0]      rng_state   = 32'h89fdbd81;
    logic             check_en    = 1'b0;

    `include "crtc_model.svh"

    video_top #(.FONT_BASE(FONT_BASE)) dut0 (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_sel_i(reg_sel_i), .reg_data_i(reg_data_i),
        .bus_addr_o(bus_addr_o), .bus_data_i(bus_data_i),
        .h_sync_o(h_sync_o), .v_sync_o(v_sync_o), .video_o(video_o)
    );

    always #10 pixel_clk_i = ~pixel_clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [7:0] read_bus(input logic [11:0] addr);
        return addr[11] ? font[addr[10:0]] : vram[addr[10:0]];
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic fill_memories();
        logic [31:0] r;
        for (int a = 0; a < 2048; a++) begin
            r       = draw();
            vram[a] = r[7:0];                   // Bit 7 gives reverse video
            font[a] = r[15:8];
        end
    endtask

    task automatic write_reg(input logic [3:0] sel, input logic [7:0] data);
        @(posedge pixel_clk_i);
        reg_wr_i   <= 1'b1;
        reg_sel_i  <= sel;
        reg_data_i <= data;
        @(posedge pixel_clk_i);
        reg_wr_i   <= 1'b0;
    endtask

    // Memory answers one cycle after the address and the model tracks its own read
    always @(posedge pixel_clk_i) begin : model_clock
        logic [7:0] rdata;
        rdata = read_bus(predict_addr());
        if (reset_i) begin
            reset_model();
        end else begin
            step_model(reg_wr_i, reg_sel_i, reg_data_i);
        end
        m_data = rdata;
        bus_data_i <= read_bus(bus_addr_o);
    end

    always @(negedge pixel_clk_i) begin
        if (check_en) begin
            compare_value("bus address", predict_addr(), bus_addr_o);
            compare_value("video", predict_video(), video_o);
            compare_value("hsync", in_window(m_hchar, m_regs[R2_H_SYNC_POS],
                          m_regs[R3_SYNC_WIDTH][3:0]), h_sync_o);
            compare_value("vsync", in_window(m_vchar, {1'b0, m_regs[R7_V_SYNC_POS][6:0]},
                          m_regs[R3_SYNC_WIDTH][7:4]), v_sync_o);
        end
    end

    // Ticks are pixel clocks for hsync and hsync rising edges for vsync
    task automatic measure_sync(input logic vertical, input int limit,
                                output int period, output int high);
        logic h_prev;
        logic s_prev;
        logic s_cur;
        logic tick;
        logic started;
        logic done;
        int   n;
        period  = 0;
        high    = 0;
        started = 1'b0;
        done    = 1'b0;
        n       = 0;
        @(negedge pixel_clk_i);
        h_prev = h_sync_o;
        s_prev = vertical ? v_sync_o : h_sync_o;
        while (!done && n < limit) begin
            @(negedge pixel_clk_i);
            n++;
            s_cur = vertical ? v_sync_o : h_sync_o;
            tick  = vertical ? (h_sync_o && !h_prev) : 1'b1;
            if (s_cur && !s_prev && started) begin
                done = 1'b1;
            end else begin
                if (s_cur && !s_prev) begin
                    started = 1'b1;
                end
                if (started && tick) begin
                    period++;
                    high += int'(s_cur);
                end
            end
            h_prev = h_sync_o;
            s_prev = s_cur;
        end
        if (!done) begin
            $display("Timeout: no full %s sync period within %0d cycles",
                     vertical ? "vertical" : "horizontal", limit);
            abort_run();
        end
    endtask

    task automatic check_timing(input string name);
        int period;
        int high;
        int lines;
        lines = int'(m_regs[R9_SCAN_LINE][4:0]) + 1;
        measure_sync(1'b0, 20000, period, high);
        compare_value({name, " hsync period"}, (m_regs[R0_H_TOTAL] + 1) * 8, period);
        compare_value({name, " hsync high"}, sync_width(m_regs[R3_SYNC_WIDTH][3:0]) * 8, high);
        measure_sync(1'b1, 400000, period, high);
        compare_value({name, " vsync period"}, (m_regs[R4_V_TOTAL][6:0] + 1) * lines, period);
        compare_value({name, " vsync high"},
                      sync_width(m_regs[R3_SYNC_WIDTH][7:4]) * lines, high);
    endtask

    // Small frame with R1 < R2 and R2 + width <= R0 on both axes
    task automatic program_small_frame();
        logic [31:0] r;
        logic [3:0]  hcode;
        logic [3:0]  vcode;
        int          total;
        int          hpos;
        int          vtotal;
        int          vpos;
        r      = draw();
        hcode  = {2'b00, r[1:0]};
        total  = (hcode == 4'd0) ? 20 : 8 + r[7:4] % 13;
        hpos   = 2 + r[15:8] % (total - sync_width(hcode) - 1);
        write_reg(R0_H_TOTAL, 8'(total));
        write_reg(R1_H_DISPLAYED, 8'(1 + r[23:16] % (hpos - 1)));
        write_reg(R2_H_SYNC_POS, 8'(hpos));
        write_reg(R9_SCAN_LINE, {6'd0, r[25:24]});
        r      = draw();
        vcode  = r[0] ? 4'd2 : 4'd1;
        vtotal = 4 + r[7:4] % 5;
        vpos   = 2 + r[15:8] % (vtotal - int'(vcode) - 1);
        write_reg(R3_SYNC_WIDTH, {vcode, hcode});
        write_reg(R4_V_TOTAL, 8'(vtotal));
        write_reg(R6_V_DISPLAYED, 8'(1 + r[23:16] % (vpos - 1)));
        write_reg(R7_V_SYNC_POS, 8'(vpos));
        r      = draw();
        write_reg(R12_DISPLAY_START_HI, {2'b00, r[5:0]});
        write_reg(R13_DISPLAY_START_LO, r[15:8]);
    endtask

    initial begin : stimulus
        logic [13:0] start;
        logic [31:0] r;
        int          period;
        int          high;
        start = {REG_DEFAULT[R12_DISPLAY_START_HI][5:0], REG_DEFAULT[R13_DISPLAY_START_LO]};
        fill_memories();
        reset_model();
        repeat (10) @(posedge pixel_clk_i);
        reset_i <= 1'b0;
        @(negedge pixel_clk_i);
        compare_value("reset hsync", 0, h_sync_o);
        compare_value("reset vsync", 0, v_sync_o);
        compare_value("reset video", 0, video_o);
        compare_value("reset bus address", {1'b0, start[10:0]}, bus_addr_o);
        @(posedge pixel_clk_i);
        check_en = 1'b1;

        check_timing("default");
        program_small_frame();
        measure_sync(1'b1, 1000000, period, high);  // Lets stale counters wrap
        check_timing("small frame");

        // Indices 14 and 15 have no register
        write_reg(4'd14, 8'hff);
        write_reg(4'd15, 8'h00);

        // Writes land at random points of the frame
        repeat (40) begin
            r = draw();
            repeat (int'(r[7:0]) + 1) begin
                @(posedge pixel_clk_i);
            end
            write_reg(r[11:8], r[19:12]);
        end
        repeat (200) @(posedge pixel_clk_i);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== src/video_top.sv ====
`timescale 1ns/1ps

module video_top import crtc_pkg::*; #(
    parameter logic [BUS_W-1:0] FONT_BASE = 12'h800
) (
    input  logic             pixel_clk_i,
    input  logic             reset_i,

    input  logic             reg_wr_i,
    input  logic [3:0]       reg_sel_i,
    input  logic [7:0]       reg_data_i,

    output logic [BUS_W-1:0] bus_addr_o,    // RAM below 12'h800, font above
    input  logic [7:0]       bus_data_i,

    output logic             h_sync_o,
    output logic             v_sync_o,
    output logic             video_o
);
    logic [CHAR_W-1:0] h_total;
    logic [CHAR_W-1:0] h_displayed;
    logic [CHAR_W-1:0] h_sync_start;
    logic [3:0]        h_sync_width;
    logic [6:0]        v_total;
    logic [6:0]        v_displayed;
    logic [6:0]        v_sync_start;
    logic [3:0]        v_sync_width;
    logic [SUB_W-1:0]  scan_lines;
    logic [MA_W-1:0]   display_start;

    logic [SUB_W-1:0]  pix;
    logic [SUB_W-1:0]  ra;
    logic              char_end;
    logic              line_end;
    logic              h_active;
    logic              frame_end;
    logic              v_active;
    logic              last_scanline;
    logic [MA_W-1:0]   ma;

    crtc_regs regs0 (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_sel_i(reg_sel_i), .reg_data_i(reg_data_i),
        .h_total_o(h_total), .h_displayed_o(h_displayed),
        .h_sync_start_o(h_sync_start), .h_sync_width_o(h_sync_width),
        .v_total_o(v_total), .v_displayed_o(v_displayed),
        .v_sync_start_o(v_sync_start), .v_sync_width_o(v_sync_width),
        .scan_lines_o(scan_lines), .display_start_o(display_start)
    );

    // Characters are always 8 pixels wide
    sync_gen h_timing (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .advance_i(1'b1), .sub_last_i(5'd7),
        .char_total_i(h_total), .char_displayed_i(h_displayed),
        .sync_start_i(h_sync_start), .sync_width_i(h_sync_width),
        .sub_o(pix), .char_end_o(char_end), .line_end_o(line_end),
        .active_o(h_active), .sync_o(h_sync_o)
    );

    // Steps once per scanline
    sync_gen v_timing (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .advance_i(line_end), .sub_last_i(scan_lines),
        .char_total_i({1'b0, v_total}), .char_displayed_i({1'b0, v_displayed}),
        .sync_start_i({1'b0, v_sync_start}), .sync_width_i(v_sync_width),
        .sub_o(ra), .char_end_o(), .line_end_o(frame_end),
        .active_o(v_active), .sync_o(v_sync_o)
    );

    // Scanline counter is about to wrap
    assign last_scanline = ra == scan_lines;

    addr_gen addr0 (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .char_end_i(char_end), .line_end_i(line_end),
        .last_scanline_i(last_scanline), .frame_end_i(frame_end),
        .displayed_i(h_displayed), .display_start_i(display_start),
        .ma_o(ma)
    );

    dot_gen #(.FONT_BASE(FONT_BASE)) dots0 (
        .pixel_clk_i(pixel_clk_i), .reset_i(reset_i),
        .pix_i(pix), .ma_i(ma), .ra_i(ra),
        .h_active_i(h_active), .v_active_i(v_active),
        .bus_addr_o(bus_addr_o), .bus_data_i(bus_data_i),
        .video_o(video_o)
    );

endmodule

// ==== src/dot_gen.sv ====
`timescale 1ns/1ps

module dot_gen import crtc_pkg::*; #(
    parameter logic [BUS_W-1:0] FONT_BASE = 12'h800    // Start of font ROM on the bus
) (
    input  logic              pixel_clk_i,
    input  logic              reset_i,

    input  logic [SUB_W-1:0]  pix_i,             // Pixel within character, 0 to 7
    input  logic [MA_W-1:0]   ma_i,
    input  logic [SUB_W-1:0]  ra_i,              // Scanline within row
    input  logic              h_active_i,
    input  logic              v_active_i,

    output logic [BUS_W-1:0]  bus_addr_o,
    input  logic [7:0]        bus_data_i,        // Valid one cycle after the address

    output logic              video_o
);
    localparam logic [SUB_W-1:0] PIX_CODE  = 5'd1;  // Code arrives from RAM
    localparam logic [SUB_W-1:0] PIX_GLYPH = 5'd3;  // Font byte arrives
    localparam logic [SUB_W-1:0] PIX_LAST  = 5'd7;

    logic [7:0]       code_q;
    logic [7:0]       glyph_q;
    logic [7:0]       shift_q;
    logic             reverse_q;
    logic             enable_q;

    logic             ram_phase;
    logic [BUS_W-1:0] ram_addr;
    logic [BUS_W-1:0] font_addr;

    // Pixels 0 and 1 address video RAM, the rest the font
    assign ram_phase = pix_i < 5'd2;
    assign ram_addr  = {1'b0, ma_i[10:0]};
    assign font_addr = FONT_BASE + BUS_W'({code_q[6:0], 3'b000}) + BUS_W'(ra_i[2:0]);

    assign bus_addr_o = ram_phase ? ram_addr : font_addr;

    always_ff @(posedge pixel_clk_i) begin
        if (pix_i == PIX_CODE) begin
            code_q <= bus_data_i;
        end
        if (pix_i == PIX_GLYPH) begin
            glyph_q <= bus_data_i;
        end
    end

    // Load at the character boundary, otherwise shift MSB first
    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            shift_q   <= 8'h00;
            reverse_q <= 1'b0;
            enable_q  <= 1'b0;
        end else if (pix_i == PIX_LAST) begin
            shift_q   <= glyph_q;
            reverse_q <= code_q[7];                 // Reverse video flag
            enable_q  <= h_active_i && v_active_i;  // Enable for the fetched character
        end else begin
            shift_q   <= {shift_q[6:0], 1'b0};
        end
    end

    assign video_o = (shift_q[7] ^ reverse_q) & enable_q;

endmodule

// ==== src/addr_gen.sv ====
`timescale 1ns/1ps

module addr_gen import crtc_pkg::*; (
    input  logic              pixel_clk_i,
    input  logic              reset_i,

    input  logic              char_end_i,        // Last pixel of a character
    input  logic              line_end_i,        // Last character of a scanline
    input  logic              last_scanline_i,   // Scanline is the last of its row
    input  logic              frame_end_i,       // Last scanline of the last row
    input  logic [CHAR_W-1:0] displayed_i,       // Characters per row, R1
    input  logic [MA_W-1:0]   display_start_i,

    output logic [MA_W-1:0]   ma_o
);
    logic [MA_W-1:0] ma_q;
    logic [MA_W-1:0] row_addr_q;
    logic [MA_W-1:0] next_row_addr;

    // Start of the following character row
    assign next_row_addr = row_addr_q + MA_W'(displayed_i);

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            ma_q       <= DISPLAY_START_DEFAULT;
            row_addr_q <= DISPLAY_START_DEFAULT;
        end else if (frame_end_i) begin
            ma_q       <= display_start_i;      // New frame
            row_addr_q <= display_start_i;
        end else if (line_end_i && last_scanline_i) begin
            ma_q       <= next_row_addr;        // Step to next row
            row_addr_q <= next_row_addr;
        end else if (line_end_i) begin
            ma_q       <= row_addr_q;           // Repeat row for next scanline
        end else if (char_end_i) begin
            ma_q       <= ma_q + 1'b1;
        end
    end

    assign ma_o = ma_q;

endmodule

// ==== src/sync_gen.sv ====
`timescale 1ns/1ps

module sync_gen import crtc_pkg::*; (
    input  logic              pixel_clk_i,
    input  logic              reset_i,

    input  logic              advance_i,         // Step the sub-counter this cycle
    input  logic [SUB_W-1:0]  sub_last_i,        // Last pixel / scanline of a character
    input  logic [CHAR_W-1:0] char_total_i,      // Last character position
    input  logic [CHAR_W-1:0] char_displayed_i,  // Number of visible characters
    input  logic [CHAR_W-1:0] sync_start_i,      // First character of sync
    input  logic [3:0]        sync_width_i,      // Sync width in characters, 0 = 16

    output logic [SUB_W-1:0]  sub_o,             // Pixel or scanline within character
    output logic              char_end_o,
    output logic              line_end_o,
    output logic              active_o,
    output logic              sync_o
);
    logic [SUB_W-1:0]  sub_q;
    logic [CHAR_W-1:0] char_q;

    logic              sub_wrap;
    logic              char_wrap;
    logic [CHAR_W:0]   sync_stop;                // One bit wider so it cannot overflow
    logic [4:0]        width_eff;

    assign sub_wrap  = sub_q == sub_last_i;
    assign char_wrap = char_q == char_total_i;

    assign char_end_o = advance_i && sub_wrap;
    assign line_end_o = char_end_o && char_wrap;

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            sub_q <= '0;
        end else if (advance_i) begin
            if (sub_wrap) begin
                sub_q <= '0;
            end else begin
                sub_q <= sub_q + 1'b1;
            end
        end
    end

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            char_q <= '0;
        end else if (char_end_o) begin
            if (char_wrap) begin
                char_q <= '0;
            end else begin
                char_q <= char_q + 1'b1;
            end
        end
    end

    // A programmed width of zero gives the full 16 characters
    assign width_eff = (sync_width_i == 4'd0) ? 5'd16 : {1'b0, sync_width_i};
    assign sync_stop = {1'b0, sync_start_i} + {{(CHAR_W-4){1'b0}}, width_eff};

    assign active_o = char_q < char_displayed_i;
    assign sync_o   = (char_q >= sync_start_i) && ({1'b0, char_q} < sync_stop);

    assign sub_o = sub_q;

endmodule

// ==== src/crtc_regs.sv ====
`timescale 1ns/1ps

module crtc_regs import crtc_pkg::*; (
    input  logic              pixel_clk_i,
    input  logic              reset_i,

    input  logic              reg_wr_i,         // Write strobe
    input  logic [3:0]        reg_sel_i,        // Register index
    input  logic [7:0]        reg_data_i,

    output logic [CHAR_W-1:0] h_total_o,        // Chars per line - 1
    output logic [CHAR_W-1:0] h_displayed_o,
    output logic [CHAR_W-1:0] h_sync_start_o,
    output logic [3:0]        h_sync_width_o,   // 0 = 16
    output logic [6:0]        v_total_o,        // Rows per frame - 1
    output logic [6:0]        v_displayed_o,
    output logic [6:0]        v_sync_start_o,
    output logic [3:0]        v_sync_width_o,   // 0 = 16
    output logic [SUB_W-1:0]  scan_lines_o,     // Scanlines per row - 1
    output logic [MA_W-1:0]   display_start_o
);
    logic [7:0] regs [REG_COUNT];

    logic       wr_valid;

    // Indices 14 and 15 have no register behind them
    assign wr_valid = reg_wr_i && (reg_sel_i < REG_COUNT);

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= REG_DEFAULT[i];
            end
        end else if (wr_valid) begin
            regs[reg_sel_i] <= reg_data_i;
        end
    end

    // Horizontal fields
    assign h_total_o      = regs[R0_H_TOTAL];
    assign h_displayed_o  = regs[R1_H_DISPLAYED];
    assign h_sync_start_o = regs[R2_H_SYNC_POS];
    assign h_sync_width_o = regs[R3_SYNC_WIDTH][3:0];   // Low nibble

    // Vertical fields are 7 bits wide on a real 6845
    assign v_total_o      = regs[R4_V_TOTAL][6:0];
    assign v_displayed_o  = regs[R6_V_DISPLAYED][6:0];
    assign v_sync_start_o = regs[R7_V_SYNC_POS][6:0];
    assign v_sync_width_o = regs[R3_SYNC_WIDTH][7:4];   // High nibble

    assign scan_lines_o   = regs[R9_SCAN_LINE][SUB_W-1:0];

    // 14-bit start address from the two halves
    assign display_start_o = {regs[R12_DISPLAY_START_HI][5:0],
                              regs[R13_DISPLAY_START_LO]};

endmodule

// ==== src/crtc_pkg.sv ====
package crtc_pkg;

    // Register indices
    localparam logic [3:0] R0_H_TOTAL           = 4'd0;
    localparam logic [3:0] R1_H_DISPLAYED       = 4'd1;
    localparam logic [3:0] R2_H_SYNC_POS        = 4'd2;
    localparam logic [3:0] R3_SYNC_WIDTH        = 4'd3;
    localparam logic [3:0] R4_V_TOTAL           = 4'd4;
    localparam logic [3:0] R5_V_ADJUST          = 4'd5;
    localparam logic [3:0] R6_V_DISPLAYED       = 4'd6;
    localparam logic [3:0] R7_V_SYNC_POS        = 4'd7;
    localparam logic [3:0] R9_SCAN_LINE         = 4'd9;
    localparam logic [3:0] R12_DISPLAY_START_HI = 4'd12;
    localparam logic [3:0] R13_DISPLAY_START_LO = 4'd13;

    localparam int REG_COUNT = 14;

    localparam int CHAR_W = 8;      // Character counters
    localparam int SUB_W  = 5;      // Pixel / scanline counters
    localparam int MA_W   = 14;     // Memory address
    localparam int BUS_W  = 12;     // Shared RAM / font bus

    // These values give roughly NTSC timing
    localparam logic [7:0] REG_DEFAULT [REG_COUNT] = '{
        8'd63,                      // R0  total chars per line - 1
        8'd40,                      // R1  displayed chars
        8'd48,                      // R2  hsync position
        8'h15,                      // R3  vsync width 1, hsync width 5
        8'd32,                      // R4  total rows - 1
        8'd0,                       // R5
        8'd25,                      // R6  displayed rows
        8'd28,                      // R7  vsync position
        8'd0,                       // R8
        8'd7,                       // R9  scanlines per row - 1
        8'd0,                       // R10
        8'd0,                       // R11
        8'h10,                      // R12 display start high
        8'h00                       // R13 display start low
    };

    localparam logic [MA_W-1:0] DISPLAY_START_DEFAULT =
        {REG_DEFAULT[R12_DISPLAY_START_HI][5:0], REG_DEFAULT[R13_DISPLAY_START_LO]};

endpackage
